/* rtl/fetch_ctrl.sv */
`timescale 1ns/10ps

module fetch_ctrl #(
    parameter logic [rvc_fetch_pkg::VADDR_WIDTH-1:0] RESET_VECTOR = 39'h0010000000
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   backend_redirect,
    input  logic [rvc_fetch_pkg::VADDR_WIDTH-1:0]  backend_redirect_pc,
    input  logic                                   block_need,
    input  logic                                   icache_ready,
    input  logic                                   icache_resp_valid,
    input  logic [63:0]                            icache_resp_data,
    input  logic                                   icache_resp_error,
    output logic                                   icache_req,
    output logic [rvc_fetch_pkg::VADDR_WIDTH-1:0]  icache_addr,
    output logic                                   block_valid,
    output rvc_fetch_pkg::fetch_block_t            block,
    output logic                                   fetch_exception,
    output logic [rvc_fetch_pkg::VADDR_WIDTH-1:0]  fetch_exception_addr
);

    localparam int VA = rvc_fetch_pkg::VADDR_WIDTH;

    rvc_fetch_pkg::fetch_state_t state;

    // Next block to fetch, always 8-byte aligned
    logic [VA-1:0] blk_addr;
    // Response in flight belongs to a flushed stream
    logic          discard;
    // A request is accepted and its response not yet seen
    logic          outstanding;

    assign outstanding = (state == rvc_fetch_pkg::REQ && icache_ready) ||
                         (state == rvc_fetch_pkg::WAIT && !icache_resp_valid);

    // Cache request level
    assign icache_req  = (state == rvc_fetch_pkg::REQ);
    assign icache_addr = blk_addr;

    // Address is frozen in FAULT, so it names the failing block
    assign fetch_exception      = (state == rvc_fetch_pkg::FAULT);
    assign fetch_exception_addr = blk_addr;

    // ======================================================================
    // Request FSM
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= rvc_fetch_pkg::IDLE;
            blk_addr    <= {RESET_VECTOR[VA-1:3], 3'b000};
            discard     <= 1'b0;
            block_valid <= 1'b0;
        end else begin
            block_valid <= 1'b0;
            if (backend_redirect) begin
                // Restart at the block holding the new PC
                blk_addr <= {backend_redirect_pc[VA-1:3], 3'b000};
                // Wait out a pending response before asking again
                discard  <= outstanding;
                state    <= outstanding ? rvc_fetch_pkg::WAIT : rvc_fetch_pkg::IDLE;
            end else begin
                case (state)
                    rvc_fetch_pkg::IDLE: begin
                        // Last block still on its way into the aligner
                        if (block_need && !block_valid) begin
                            state <= rvc_fetch_pkg::REQ;
                        end
                    end
                    rvc_fetch_pkg::REQ: begin
                        if (icache_ready) begin
                            state <= rvc_fetch_pkg::WAIT;
                        end
                    end
                    rvc_fetch_pkg::WAIT: begin
                        if (icache_resp_valid) begin
                            if (discard) begin
                                // Stale data, drop it
                                discard <= 1'b0;
                                state   <= rvc_fetch_pkg::IDLE;
                            end else if (icache_resp_error) begin
                                state <= rvc_fetch_pkg::FAULT;
                            end else begin
                                block_valid <= 1'b1;
                                blk_addr    <= blk_addr + VA'(8);
                                state       <= rvc_fetch_pkg::IDLE;
                            end
                        end
                    end
                    // FAULT parks until a redirect
                    default: state <= state;
                endcase
            end
        end
    end

    // Response payload, qualified by block_valid
    always_ff @(posedge clk) begin
        if (state == rvc_fetch_pkg::WAIT && icache_resp_valid) begin
            block.data <= icache_resp_data;
            block.addr <= blk_addr;
        end
    end

endmodule

/* rtl/halfword_aligner.sv */
`timescale 1ns/10ps

module halfword_aligner #(
    parameter logic [rvc_fetch_pkg::VADDR_WIDTH-1:0] RESET_VECTOR = 39'h0010000000
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   backend_redirect,
    input  logic [rvc_fetch_pkg::VADDR_WIDTH-1:0]  backend_redirect_pc,
    input  logic                                   block_valid,
    input  rvc_fetch_pkg::fetch_block_t            block,
    input  logic                                   take,
    output logic                                   block_need,
    output logic                                   instr_valid,
    output rvc_fetch_pkg::aligned_instr_t          instr
);

    localparam int VA      = rvc_fetch_pkg::VADDR_WIDTH;
    localparam int OFF_W   = $clog2(rvc_fetch_pkg::BLOCK_HW);
    // Lowest PC bit above the block offset
    localparam int BLK_LSB = OFF_W + 1;

    // ======================================================================
    // State
    // ======================================================================
    logic [VA-1:0]               pc;
    rvc_fetch_pkg::fetch_block_t blk;
    logic                        blk_valid;
    // Low half of a 32-bit instruction that spans two blocks
    logic [15:0]                 carry;
    logic                        carry_valid;

    // ======================================================================
    // Extraction
    // ======================================================================
    logic [OFF_W-1:0] off;
    logic             last_hw;
    logic             blk_match;
    logic [15:0]      lo;
    logic [15:0]      hi;
    logic             is32;
    logic             split;
    logic [VA-1:0]    pc_next;
    logic             release_blk;

    assign off     = pc[OFF_W:1];
    assign last_hw = (off == OFF_W'(rvc_fetch_pkg::BLOCK_HW - 1));

    // Buffered block must be the one the PC points into
    assign blk_match = carry_valid ?
                       (blk.addr[VA-1:BLK_LSB] == pc[VA-1:BLK_LSB] + 1'b1) :
                       (blk.addr[VA-1:BLK_LSB] == pc[VA-1:BLK_LSB]);

    // With carry held, upper half is halfword 0 of the new block
    assign lo   = carry_valid ? carry : blk.data[off];
    assign hi   = carry_valid ? blk.data[0] : blk.data[off + 1'b1];
    assign is32 = carry_valid || (lo[1:0] == 2'b11);

    // 32-bit start in the last halfword, upper half not here yet
    assign split = !carry_valid && is32 && last_hw && blk_valid && blk_match;

    assign pc_next     = pc + (is32 ? VA'(4) : VA'(2));
    // Next instruction starts in the following block
    assign release_blk = !carry_valid && (pc_next[VA-1:BLK_LSB] != pc[VA-1:BLK_LSB]);

    assign block_need  = !blk_valid;
    assign instr_valid = blk_valid && blk_match && !(is32 && last_hw && !carry_valid);

    assign instr.pc            = pc;
    assign instr.bits          = is32 ? {hi, lo} : {16'h0000, lo};
    assign instr.is_compressed = !is32;

    // ======================================================================
    // Control registers
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc          <= RESET_VECTOR;
            blk_valid   <= 1'b0;
            carry_valid <= 1'b0;
        end else if (backend_redirect) begin
            // Flush buffer and carry, jump
            pc          <= {backend_redirect_pc[VA-1:1], 1'b0};
            blk_valid   <= 1'b0;
            carry_valid <= 1'b0;
        end else if (block_valid) begin
            blk_valid <= 1'b1;
        end else if (split) begin
            // Park the low half, ask for the next block
            carry_valid <= 1'b1;
            blk_valid   <= 1'b0;
        end else if (take) begin
            pc          <= pc_next;
            carry_valid <= 1'b0;
            if (release_blk) begin
                blk_valid <= 1'b0;
            end
        end
    end

    // Payload, qualified by the valid flags above
    always_ff @(posedge clk) begin
        if (block_valid) begin
            blk <= block;
        end
        if (split) begin
            carry <= lo;
        end
    end

endmodule

/* rtl/instr_classifier.sv */
`timescale 1ns/10ps

module instr_classifier (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            backend_redirect,
    input  logic                            backend_stall,
    input  logic                            instr_valid,
    input  rvc_fetch_pkg::aligned_instr_t   instr,
    output logic                            take,
    output logic                            out_valid,
    output rvc_fetch_pkg::frontend_packet_t out
);

    rvc_fetch_pkg::instr_class_t iclass;
    // Output register free to accept a new packet
    logic                        load;

    // ======================================================================
    // Opcode class
    // ======================================================================
    always_comb begin
        if (instr.is_compressed) begin
            iclass = rvc_fetch_pkg::COMPRESSED;
        end else begin
            case (instr.bits[6:0])
                // LUI, AUIPC, OP-IMM(-32), OP(-32)
                7'h37, 7'h17, 7'h13, 7'h1B, 7'h33, 7'h3B:
                    iclass = rvc_fetch_pkg::ALU;
                7'h03: iclass = rvc_fetch_pkg::LOAD;
                7'h23: iclass = rvc_fetch_pkg::STORE;
                7'h63: iclass = rvc_fetch_pkg::BRANCH;
                // JAL, JALR
                7'h6F, 7'h67: iclass = rvc_fetch_pkg::JUMP;
                7'h73: iclass = rvc_fetch_pkg::SYSTEM;
                7'h0F: iclass = rvc_fetch_pkg::FENCE;
                // FP load/store, fused ops, OP-FP
                7'h07, 7'h27, 7'h43, 7'h47, 7'h4B, 7'h4F, 7'h53:
                    iclass = rvc_fetch_pkg::FP;
                7'h2F: iclass = rvc_fetch_pkg::AMO;
                default: iclass = rvc_fetch_pkg::UNKNOWN;
            endcase
        end
    end

    // ======================================================================
    // Output stage
    // ======================================================================

    // Empty register fills even under stall
    assign load = !out_valid || !backend_stall;
    assign take = instr_valid && load && !backend_redirect;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (backend_redirect) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= instr_valid;
        end
    end

    // Packet payload, held while stalled
    always_ff @(posedge clk) begin
        if (take) begin
            out.instr  <= instr;
            out.iclass <= iclass;
        end
    end

endmodule

/* rtl/rvc_fetch_pkg.sv */
package rvc_fetch_pkg;

    // ======================================================================
    // Widths
    // ======================================================================

    // Sv39 virtual address
    parameter int VADDR_WIDTH = 39;

    // Halfwords per 64-bit cache block
    parameter int BLOCK_HW = 4;

    // ======================================================================
    // Enums
    // ======================================================================

    // Coarse opcode class sent to the backend
    typedef enum logic [3:0] {
        COMPRESSED,
        ALU,
        LOAD,
        STORE,
        BRANCH,
        JUMP,
        SYSTEM,
        FENCE,
        FP,
        AMO,
        UNKNOWN
    } instr_class_t;

    // Cache request FSM in fetch_ctrl
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT,
        FAULT
    } fetch_state_t;

    // ======================================================================
    // Structs
    // ======================================================================

    // One cache response, halfword 0 in the low bits
    typedef struct packed {
        logic [BLOCK_HW-1:0][15:0] data;
        logic [VADDR_WIDTH-1:0]    addr;
    } fetch_block_t;

    // Extracted instruction, upper half zero when compressed
    typedef struct packed {
        logic [VADDR_WIDTH-1:0] pc;
        logic [31:0]            bits;
        logic                   is_compressed;
    } aligned_instr_t;

    // Output packet
    typedef struct packed {
        aligned_instr_t instr;
        instr_class_t   iclass;
    } frontend_packet_t;

endpackage

/* rtl/rvc_frontend.sv */
`timescale 1ns/10ps

module rvc_frontend #(
    parameter logic [rvc_fetch_pkg::VADDR_WIDTH-1:0] RESET_VECTOR = 39'h0010000000
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    // Cache side
    output logic                                   icache_req,
    output logic [rvc_fetch_pkg::VADDR_WIDTH-1:0]  icache_addr,
    input  logic                                   icache_ready,
    input  logic                                   icache_resp_valid,
    input  logic [63:0]                            icache_resp_data,
    input  logic                                   icache_resp_error,
    // Backend side
    input  logic                                   backend_redirect,
    input  logic [rvc_fetch_pkg::VADDR_WIDTH-1:0]  backend_redirect_pc,
    input  logic                                   backend_stall,
    output logic                                   out_valid,
    output rvc_fetch_pkg::frontend_packet_t        out,
    output logic                                   fetch_exception,
    output logic [rvc_fetch_pkg::VADDR_WIDTH-1:0]  fetch_exception_addr
);

    // Fetch to aligner
    logic                          block_valid;
    rvc_fetch_pkg::fetch_block_t   block;
    logic                          block_need;
    // Aligner to classifier
    logic                          instr_valid;
    rvc_fetch_pkg::aligned_instr_t instr;
    logic                          take;

    fetch_ctrl #(
        .RESET_VECTOR(RESET_VECTOR)
    ) u_fetch_ctrl (
        .clk                 (clk),
        .rst_n               (rst_n),
        .backend_redirect    (backend_redirect),
        .backend_redirect_pc (backend_redirect_pc),
        .block_need          (block_need),
        .icache_ready        (icache_ready),
        .icache_resp_valid   (icache_resp_valid),
        .icache_resp_data    (icache_resp_data),
        .icache_resp_error   (icache_resp_error),
        .icache_req          (icache_req),
        .icache_addr         (icache_addr),
        .block_valid         (block_valid),
        .block               (block),
        .fetch_exception     (fetch_exception),
        .fetch_exception_addr(fetch_exception_addr)
    );

    halfword_aligner #(
        .RESET_VECTOR(RESET_VECTOR)
    ) u_aligner (
        .clk                (clk),
        .rst_n              (rst_n),
        .backend_redirect   (backend_redirect),
        .backend_redirect_pc(backend_redirect_pc),
        .block_valid        (block_valid),
        .block              (block),
        .take               (take),
        .block_need         (block_need),
        .instr_valid        (instr_valid),
        .instr              (instr)
    );

    instr_classifier u_classifier (
        .clk             (clk),
        .rst_n           (rst_n),
        .backend_redirect(backend_redirect),
        .backend_stall   (backend_stall),
        .instr_valid     (instr_valid),
        .instr           (instr),
        .take            (take),
        .out_valid       (out_valid),
        .out             (out)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run with Verilator, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rvc_frontend -f rvc_frontend.f -o sim_rvc_frontend \
    > build.log 2>&1 &&
./obj_dir/sim_rvc_frontend > sim.log 2>&1
grep -q "^RESULT: PASS$" sim.log && echo "simulation passed" || {
    echo "simulation failed, see build.log and sim.log"
    exit 1
}

/* rvc_frontend.f */
rtl/rvc_fetch_pkg.sv
rtl/fetch_ctrl.sv
rtl/halfword_aligner.sv
rtl/instr_classifier.sv
rtl/rvc_frontend.sv
tb/rvc_frontend_checker.sv
tb/tb_rvc_frontend.sv

/* tb/rvc_frontend_checker.sv */
`timescale 1ns/10ps

module rvc_frontend_checker (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            out_valid,
    input rvc_fetch_pkg::frontend_packet_t out,
    input logic                            backend_stall,
    input logic                            backend_redirect,
    input logic                            icache_req,
    input logic                            icache_ready
);

    // ======================================================================
    // Output stage
    // ======================================================================

    // Held packet under stall
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && backend_stall && !backend_redirect |=> out_valid && $stable(out))
        else $error("output changed under stall");

    // Even PCs only
    assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> !out.instr.pc[0])
        else $error("odd output pc");

    assert property (@(posedge clk) disable iff (!rst_n) backend_redirect |=> !out_valid)
        else $error("output valid after redirect");

    // Cache request level drops only on acceptance or redirect
    assert property (@(posedge clk) disable iff (!rst_n)
        icache_req && !icache_ready && !backend_redirect |=> icache_req)
        else $error("request dropped without ready");

endmodule

/* tb/tb_rvc_frontend.sv */
`timescale 1ns/10ps

module tb_rvc_frontend;

    localparam logic [38:0] BASE = 39'h0010000000;
    localparam int PROG_HW = 4096;
    // About 400 instructions at up to 12 cycles each plus margin
    localparam int MAX_CYCLES = 6000;

    logic clk;
    logic rst_n;
    logic icache_req;
    logic [38:0] icache_addr;
    logic icache_ready;
    logic icache_resp_valid;
    logic [63:0] icache_resp_data;
    logic icache_resp_error;
    logic backend_redirect;
    logic [38:0] backend_redirect_pc;
    logic backend_stall;
    logic out_valid;
    rvc_fetch_pkg::frontend_packet_t out;
    logic fetch_exception;
    logic [38:0] fetch_exception_addr;

    // ======================================================================
    // Program memory, LFSR and cache model state
    // ======================================================================
    logic [15:0] prog [PROG_HW];
    logic [6:0] op_table [16] = '{7'h37, 7'h17, 7'h13, 7'h33, 7'h03, 7'h23, 7'h63, 7'h6F,
                                  7'h67, 7'h73, 7'h0F, 7'h07, 7'h53, 7'h2F, 7'h5B, 7'h1B};
    logic [31:0] lfsr = 32'hc64e_0b62;
    int cycles = 0;
    int got = 0;
    int splits = 0;
    logic [15:0] class_mask = '0;
    logic [38:0] exp_pc = BASE;
    string cur_test = "reset";
    int b_start = -1;
    int c_start = -1;
    // Cache model
    logic pending = 1'b0;
    logic [38:0] pend_addr;
    logic [1:0] wait_cnt;
    logic err_armed = 1'b0;
    logic [38:0] err_addr;

    rvc_frontend #(.RESET_VECTOR(BASE)) UUT (.*);

    bind rvc_frontend rvc_frontend_checker u_checker (
        .clk(clk), .rst_n(rst_n), .out_valid(out_valid), .out(out),
        .backend_stall(backend_stall), .backend_redirect(backend_redirect),
        .icache_req(icache_req), .icache_ready(icache_ready)
    );

    always #10 clk = ~clk;

    // One Galois step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic b;
        v = '0;
        for (int k = 0; k < n; k++) begin
            b = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ 32'h8020_0003;
            end
            v = {v[30:0], b};
        end
        return v;
    endfunction

    // Outside the program window every halfword comes from its full address
    function automatic logic [15:0] hw_at(input logic [38:0] a);
        logic [38:0] idx;
        idx = (a - BASE) >> 1;
        if (a >= BASE && idx < PROG_HW) begin
            return prog[idx];
        end
        return a[15:0] ^ a[31:16] ^ {9'h000, a[38:32]} ^ 16'h5a5a;
    endfunction

    function automatic rvc_fetch_pkg::instr_class_t class_of(input logic [6:0] op);
        case (op)
            7'h37, 7'h17, 7'h13, 7'h1B, 7'h33, 7'h3B: return rvc_fetch_pkg::ALU;
            7'h03: return rvc_fetch_pkg::LOAD;
            7'h23: return rvc_fetch_pkg::STORE;
            7'h63: return rvc_fetch_pkg::BRANCH;
            7'h6F, 7'h67: return rvc_fetch_pkg::JUMP;
            7'h73: return rvc_fetch_pkg::SYSTEM;
            7'h0F: return rvc_fetch_pkg::FENCE;
            7'h07, 7'h27, 7'h43, 7'h47, 7'h4B, 7'h4F, 7'h53: return rvc_fetch_pkg::FP;
            7'h2F: return rvc_fetch_pkg::AMO;
            default: return rvc_fetch_pkg::UNKNOWN;
        endcase
    endfunction

    // Reference model of one extracted instruction
    function automatic rvc_fetch_pkg::frontend_packet_t expect_packet(input logic [38:0] pc);
        rvc_fetch_pkg::frontend_packet_t p;
        logic [15:0] lo;
        lo = hw_at(pc);
        p.instr.pc = pc;
        p.instr.is_compressed = (lo[1:0] != 2'b11);
        if (p.instr.is_compressed) begin
            p.instr.bits = {16'h0000, lo};
            p.iclass = rvc_fetch_pkg::COMPRESSED;
        end else begin
            p.instr.bits = {hw_at(pc + 39'd2), lo};
            p.iclass = class_of(lo[6:0]);
        end
        return p;
    endfunction

    task automatic check_value(input string what, input logic [127:0] exp_v,
                               input logic [127:0] act_v);
        if (exp_v !== act_v) begin
            $display("mismatch %s/%s expected %h actual %h", cur_test, what, exp_v, act_v);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // Region B puts every 32-bit start at halfword 3 and region C walks the opcode table
    task automatic build_program();
        int i;
        int k;
        logic is32;
        logic [6:0] op;
        logic [31:0] w;
        logic [15:0] h;
        i = 0;
        k = 0;
        while (i < PROG_HW) begin
            if (i >= 1024 && i < 1280) begin
                if (b_start < 0) b_start = i;
                is32 = (i % 4 == 3);
                op = op_table[rand_bits(4)];
            end else if (i >= 1280 && k < 32) begin
                if (c_start < 0) c_start = i;
                is32 = !k[0];
                op = op_table[k >> 1];
                k++;
            end else begin
                is32 = rand_bits(2) >= 2;
                op = op_table[rand_bits(4)];
            end
            if (i == PROG_HW - 1) is32 = 1'b0;
            if (is32) begin
                w = 32'({rand_bits(25), op});
                prog[i] = w[15:0];
                prog[i+1] = w[31:16];
                i += 2;
            end else begin
                h = 16'(rand_bits(16));
                if (h[1:0] == 2'b11) h[1:0] = 2'b01;
                prog[i] = h;
                i++;
            end
        end
    endtask

    // ======================================================================
    // Cache model with one response per accepted request
    // ======================================================================
    always @(posedge clk) begin
        logic accepted;
        logic [38:0] req_addr;
        logic [1:0] lat;
        logic ready_next;
        accepted = icache_req && icache_ready;
        req_addr = icache_addr;
        lat = 2'd0;
        if (accepted) begin
            check_value("icache_addr_align", 0, req_addr[2:0]);
            // Latency of 1 to 4 cycles
            lat = 2'(rand_bits(2));
        end
        // Ready about three cycles out of four
        ready_next = rand_bits(2) != 0;
        #2;
        icache_ready = ready_next;
        icache_resp_valid = 1'b0;
        if (pending) begin
            if (wait_cnt == 0) begin
                icache_resp_valid = 1'b1;
                icache_resp_data = {hw_at(pend_addr + 39'd6), hw_at(pend_addr + 39'd4),
                                    hw_at(pend_addr + 39'd2), hw_at(pend_addr)};
                icache_resp_error = err_armed && (pend_addr == err_addr);
                pending = 1'b0;
            end else begin
                wait_cnt = wait_cnt - 1'b1;
            end
        end
        if (accepted) begin
            pending = 1'b1;
            pend_addr = req_addr;
            wait_cnt = lat;
        end
    end

    // Output monitor against the reference model
    always @(posedge clk) begin
        rvc_fetch_pkg::frontend_packet_t e;
        if (rst_n) begin
            if (backend_redirect) begin
                exp_pc = backend_redirect_pc;
            end else if (out_valid && !backend_stall) begin
                e = expect_packet(exp_pc);
                check_value("packet", e, out);
                class_mask[out.iclass] = 1'b1;
                if (!out.instr.is_compressed && out.instr.pc[2:1] == 2'd3) splits++;
                exp_pc = exp_pc + (e.instr.is_compressed ? 39'd2 : 39'd4);
                got++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout in test %s after %0d cycles", cur_test, cycles);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

    // ======================================================================
    // Test tasks
    // ======================================================================
    task automatic collect(input int n);
        int target;
        target = got + n;
        while (got < target) @(posedge clk);
    endtask

    // Called right after a rising edge
    task automatic pulse_redirect(input logic [38:0] pc);
        #2;
        backend_redirect = 1'b1;
        backend_redirect_pc = pc;
        @(posedge clk);
        #2;
        backend_redirect = 1'b0;
    endtask

    task automatic redirect_while_pending(input logic [38:0] pc);
        do @(posedge clk); while (!(icache_req && icache_ready));
        pulse_redirect(pc);
    endtask

    task automatic test_sequential();
        cur_test = "sequential";
        collect(80);
    endtask

    task automatic test_split();
        cur_test = "split";
        @(posedge clk);
        pulse_redirect(BASE + 39'(2 * b_start));
        splits = 0;
        collect(60);
        check_value("split_seen", 1, splits > 0);
    endtask

    task automatic test_redirect();
        cur_test = "redirect";
        redirect_while_pending(BASE + 39'h322);
        collect(20);
        redirect_while_pending(BASE + 39'h4a6);
        collect(20);
    endtask

    task automatic test_stall();
        int target;
        cur_test = "stall";
        target = got + 100;
        while (got < target) begin
            @(posedge clk);
            #2;
            backend_stall = 1'(rand_bits(1));
        end
        @(posedge clk);
        #2;
        backend_stall = 1'b0;
    endtask

    task automatic test_error();
        logic [38:0] start;
        logic [15:0] tail;
        cur_test = "error";
        start = BASE + 39'h1800;
        err_addr = start + 39'd40;
        err_armed = 1'b1;
        @(posedge clk);
        pulse_redirect(start);
        while (!fetch_exception) @(posedge clk);
        check_value("exc_addr", err_addr, fetch_exception_addr);
        repeat (20) @(posedge clk);
        // Drained up to the faulting block or to a 32-bit start parked in carry
        tail = hw_at(err_addr - 39'd2);
        check_value("drained", 1,
                    exp_pc == err_addr ||
                    (exp_pc == err_addr - 39'd2 && tail[1:0] == 2'b11));
        err_armed = 1'b0;
        pulse_redirect(err_addr + 39'd2);
        check_value("exc_clear", 0, fetch_exception);
        collect(30);
    endtask

    task automatic test_classes();
        cur_test = "classes";
        @(posedge clk);
        pulse_redirect(BASE + 39'(2 * c_start));
        class_mask = '0;
        collect(32);
        check_value("class_mask", 16'h07ff, class_mask);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        icache_ready = 1'b1;
        icache_resp_valid = 1'b0;
        icache_resp_data = '0;
        icache_resp_error = 1'b0;
        backend_redirect = 1'b0;
        backend_redirect_pc = '0;
        backend_stall = 1'b0;
        build_program();
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_sequential();
        test_redirect();
        test_stall();
        test_split();
        test_error();
        test_classes();
        $display("RESULT: PASS");
        $finish;
    end

endmodule
